//--- hdl/gfx_pkg.sv
// shared types for the raster graphics subsystem
// coordinates, colour index, rectangle command, pixel write, scan and display

package gfx_pkg;

    localparam int CORDW = 16;  // coordinate width
    localparam int CIDXW = 4;   // colour index width

    typedef logic signed [CORDW-1:0] coord_t;  // screen and framebuffer position
    typedef logic [CIDXW-1:0] cidx_t;          // colour index per pixel

    // one rectangle command, corners in any order
    typedef struct packed {
        coord_t x0;    // first corner x
        coord_t y0;    // first corner y
        coord_t x1;    // second corner x
        coord_t y1;    // second corner y
        cidx_t  cidx;  // fill colour
    } rect_t;

    // one framebuffer write from the drawer
    typedef struct packed {
        logic   we;    // write strobe
        coord_t x;     // pixel column
        coord_t y;     // pixel row
        cidx_t  cidx;  // colour to store
    } pix_wr_t;

    // scan state from the timing generator
    typedef struct packed {
        coord_t sx;     // horizontal position
        coord_t sy;     // vertical position
        logic   de;     // active area
        logic   hsync;  // horizontal sync, active high
        logic   vsync;  // vertical sync, active high
        logic   frame;  // start of frame pulse
    } scan_pos_t;

    // display output
    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        cidx_t pix;  // colour index, 0 outside de
    } vga_out_t;

endpackage

//--- hdl/rect_fill_draw.sv
// filled rectangle drawer
// clears the framebuffer after reset, then fills one clipped rectangle
// per four-phase req/ack command, one pixel per cycle in row-major order
`timescale 1ns/100ps

module rect_fill_draw #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 24
) (
    input  logic             clk_100m,
    input  logic             rst,
    input  gfx_pkg::rect_t   cmd,      // rectangle command, stable while cmd_req
    input  logic             cmd_req,
    output logic             cmd_ack,
    output gfx_pkg::pix_wr_t pix_wr    // one framebuffer write per cycle
);
    import gfx_pkg::*;

    localparam coord_t X_MAX = coord_t'(FB_WIDTH - 1);   // rightmost column
    localparam coord_t Y_MAX = coord_t'(FB_HEIGHT - 1);  // bottom row

    typedef enum logic [2:0] {CLEAR, IDLE, SETUP, FILL, ACK} state_t;
    state_t state;

    rect_t  cmd_r;   // latched command
    coord_t cur_x;   // pixel being written
    coord_t cur_y;
    coord_t x_lo;    // clipped left edge, row restart
    coord_t x_hi;    // clipped right edge
    coord_t y_hi;    // clipped bottom edge

    coord_t lx, rx, ty, by;          // ordered corners
    coord_t lx_c, rx_c, ty_c, by_c;  // clamped to the framebuffer
    logic   off_screen;              // nothing left to draw

    // corner ordering and clipping, used in SETUP
    always_comb begin
        lx = (cmd_r.x0 < cmd_r.x1) ? cmd_r.x0 : cmd_r.x1;  // left is min
        rx = (cmd_r.x0 < cmd_r.x1) ? cmd_r.x1 : cmd_r.x0;
        ty = (cmd_r.y0 < cmd_r.y1) ? cmd_r.y0 : cmd_r.y1;  // top is min
        by = (cmd_r.y0 < cmd_r.y1) ? cmd_r.y1 : cmd_r.y0;
        lx_c = (lx < 0) ? '0 : lx;
        rx_c = (rx > X_MAX) ? X_MAX : rx;
        ty_c = (ty < 0) ? '0 : ty;
        by_c = (by > Y_MAX) ? Y_MAX : by;
        off_screen = (rx < 0) || (lx > X_MAX) || (by < 0) || (ty > Y_MAX);
    end

    // command and edge registers
    always_ff @(posedge clk_100m) begin
        if (state == IDLE && cmd_req) begin
            cmd_r <= cmd;  // sample on acceptance
        end
        if (state == SETUP) begin
            x_lo <= lx_c;
            x_hi <= rx_c;
            y_hi <= by_c;
        end
    end

    always_ff @(posedge clk_100m) begin
        if (rst) begin
            state   <= CLEAR;  // clear pass starts straight out of reset
            cur_x   <= '0;
            cur_y   <= '0;
            cmd_ack <= 1'b0;
        end else begin
            case (state)
                CLEAR: begin  // sweep whole framebuffer with index 0
                    if (cur_x == X_MAX) begin
                        cur_x <= '0;
                        if (cur_y == Y_MAX) begin
                            cur_y <= '0;
                            state <= IDLE;  // last clear pixel
                        end else begin
                            cur_y <= cur_y + coord_t'(1);
                        end
                    end else begin
                        cur_x <= cur_x + coord_t'(1);
                    end
                end
                IDLE: begin
                    if (cmd_req) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin  // normalize cycle
                    cur_x <= lx_c;
                    cur_y <= ty_c;
                    if (off_screen) begin
                        cmd_ack <= 1'b1;  // empty, ack right away
                        state   <= ACK;
                    end else begin
                        state <= FILL;
                    end
                end
                FILL: begin
                    if (cur_x == x_hi) begin
                        cur_x <= x_lo;  // back to left edge
                        if (cur_y == y_hi) begin
                            cmd_ack <= 1'b1;  // high the cycle after last write
                            state   <= ACK;
                        end else begin
                            cur_y <= cur_y + coord_t'(1);
                        end
                    end else begin
                        cur_x <= cur_x + coord_t'(1);
                    end
                end
                ACK: begin
                    if (!cmd_req) begin
                        cmd_ack <= 1'b0;  // requester let go
                        state   <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // write port, index 0 during the clear pass
    always_comb begin
        pix_wr.we   = (state == CLEAR) || (state == FILL);
        pix_wr.x    = cur_x;
        pix_wr.y    = cur_y;
        pix_wr.cidx = (state == FILL) ? cmd_r.cidx : '0;
    end

endmodule

//--- hdl/scan_timing.sv
// display scan timing generator
// horizontal and vertical counters with registered sync, enable and frame start
`timescale 1ns/100ps

module scan_timing #(
    parameter int FB_WIDTH     = 32,  // active width
    parameter int FB_HEIGHT    = 24,  // active height
    parameter int H_TOTAL      = 40,
    parameter int V_TOTAL      = 28,
    parameter int H_SYNC_START = 34,
    parameter int H_SYNC_LEN   = 3,
    parameter int V_SYNC_START = 25,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic               clk_100m,
    input  logic               rst,
    output gfx_pkg::scan_pos_t scan
);
    import gfx_pkg::*;

    localparam coord_t H_LAST  = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST  = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT   = coord_t'(FB_WIDTH);
    localparam coord_t V_ACT   = coord_t'(FB_HEIGHT);
    localparam coord_t HS_BEG  = coord_t'(H_SYNC_START);
    localparam coord_t HS_END  = coord_t'(H_SYNC_START + H_SYNC_LEN);  // first col after sync
    localparam coord_t VS_BEG  = coord_t'(V_SYNC_START);
    localparam coord_t VS_END  = coord_t'(V_SYNC_START + V_SYNC_LEN);

    coord_t h_cnt;  // current column
    coord_t v_cnt;  // current line
    logic   de_n;
    logic   hs_n;
    logic   vs_n;
    logic   frame_n;

    // position counters
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;  // end of line
            if (v_cnt == V_LAST) begin
                v_cnt <= '0;  // end of frame
            end else begin
                v_cnt <= v_cnt + coord_t'(1);
            end
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // decode for the current position
    always_comb begin
        de_n    = (h_cnt < H_ACT) && (v_cnt < V_ACT);
        hs_n    = (h_cnt >= HS_BEG) && (h_cnt < HS_END);
        vs_n    = (v_cnt >= VS_BEG) && (v_cnt < VS_END);  // whole lines
        frame_n = (h_cnt == 0) && (v_cnt == 0);
    end

    // registered scan state, one cycle behind the counters
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            scan <= '0;
        end else begin
            scan.sx    <= h_cnt;
            scan.sy    <= v_cnt;
            scan.de    <= de_n;
            scan.hsync <= hs_n;
            scan.vsync <= vs_n;
            scan.frame <= frame_n;
        end
    end

endmodule

//--- hdl/frame_store.sv
// dual-port frame store
// takes drawer writes and returns the colour index of each scanned pixel,
// with sync and enable delayed to match the one-cycle read
`timescale 1ns/100ps

module frame_store #(
    parameter int FB_WIDTH  = 32,
    parameter int FB_HEIGHT = 24
) (
    input  logic               clk_100m,
    input  logic               rst,
    input  gfx_pkg::pix_wr_t   pix_wr,  // write port from the drawer
    input  gfx_pkg::scan_pos_t scan,    // read side from scan timing
    output gfx_pkg::vga_out_t  vga
);
    import gfx_pkg::*;

    localparam int DEPTH = FB_WIDTH * FB_HEIGHT;  // one entry per pixel
    localparam int ADDRW = $clog2(DEPTH);

    cidx_t mem [DEPTH];  // pixel memory, no reset

    logic [ADDRW-1:0] wr_addr;
    logic [ADDRW-1:0] rd_addr;
    logic             wr_ok;    // write lands inside the framebuffer
    cidx_t            rd_pix;   // read data, one cycle after rd_addr
    logic             hsync_d;  // scan state delayed to match rd_pix
    logic             vsync_d;
    logic             de_d;

    // linear address, row-major
    function automatic logic [ADDRW-1:0] pix_addr(input coord_t x, input coord_t y);
        int lin;
        lin = int'(y) * FB_WIDTH + int'(x);
        return ADDRW'(lin);
    endfunction

    // true for a position inside the framebuffer
    function automatic logic in_fb(input coord_t x, input coord_t y);
        return (x >= 0) && (x < FB_WIDTH) && (y >= 0) && (y < FB_HEIGHT);
    endfunction

    // write side
    always_comb begin
        wr_ok   = pix_wr.we && in_fb(pix_wr.x, pix_wr.y);  // drop stray writes
        wr_addr = pix_addr(pix_wr.x, pix_wr.y);
    end

    always_ff @(posedge clk_100m) begin
        if (wr_ok) begin
            mem[wr_addr] <= pix_wr.cidx;  // never stalls
        end
    end

    // read side, address only meaningful in the active area
    always_comb begin
        rd_addr = scan.de ? pix_addr(scan.sx, scan.sy) : '0;
    end

    always_ff @(posedge clk_100m) begin
        rd_pix <= mem[rd_addr];  // old data on a same-cycle write
    end

    // line up sync and enable with the read data
    always_ff @(posedge clk_100m) begin
        if (rst) begin
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
            de_d    <= 1'b0;
        end else begin
            hsync_d <= scan.hsync;
            vsync_d <= scan.vsync;
            de_d    <= scan.de;
        end
    end

    // display output, pixel blanked outside the active area
    always_comb begin
        vga.hsync = hsync_d;
        vga.vsync = vsync_d;
        vga.de    = de_d;
        vga.pix   = de_d ? rd_pix : '0;
    end

endmodule

//--- hdl/gfx_top.sv
// raster graphics subsystem top level
// rectangle drawer, scan timing and frame store on one clock
`timescale 1ns/100ps

module gfx_top #(
    parameter int FB_WIDTH     = 32,  // framebuffer and active area width
    parameter int FB_HEIGHT    = 24,  // framebuffer and active area height
    parameter int H_TOTAL      = 40,  // clocks per line
    parameter int V_TOTAL      = 28,  // lines per frame
    parameter int H_SYNC_START = 34,
    parameter int H_SYNC_LEN   = 3,
    parameter int V_SYNC_START = 25,
    parameter int V_SYNC_LEN   = 2
) (
    input  logic              clk_100m,
    input  logic              rst,
    input  gfx_pkg::rect_t    cmd,      // rectangle command
    input  logic              cmd_req,
    output logic              cmd_ack,
    output gfx_pkg::vga_out_t vga       // display output
);
    import gfx_pkg::*;

    pix_wr_t   pix_wr;  // drawer to frame store
    scan_pos_t scan;    // timing to frame store

    rect_fill_draw #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_draw (
        .clk_100m (clk_100m),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .pix_wr   (pix_wr)
    );

    scan_timing #(
        .FB_WIDTH     (FB_WIDTH),
        .FB_HEIGHT    (FB_HEIGHT),
        .H_TOTAL      (H_TOTAL),
        .V_TOTAL      (V_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) u_scan (
        .clk_100m (clk_100m),
        .rst      (rst),
        .scan     (scan)
    );

    frame_store #(
        .FB_WIDTH  (FB_WIDTH),
        .FB_HEIGHT (FB_HEIGHT)
    ) u_fb (
        .clk_100m (clk_100m),
        .rst      (rst),
        .pix_wr   (pix_wr),
        .scan     (scan),
        .vga      (vga)
    );

endmodule

//--- tb/clk_gen.sv
// testbench clock and reset source
// 10 ns clock, synchronous reset held over the first two rising edges
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD = 5,  // ns
    parameter int RST_CYCLES  = 2
) (
    output logic clk_100m,
    output logic rst
);

    initial begin
        clk_100m = 1'b0;
        forever #(HALF_PERIOD) clk_100m = ~clk_100m;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_100m);
        @(negedge clk_100m);  // release away from the sampling edge
        rst = 1'b0;
    end

endmodule

//--- tb/tb_gfx_top.sv
// testbench for the raster graphics subsystem
// applies a table of rectangle commands, keeps a reference framebuffer
// and checks every pixel and sync of one frame after each command
`timescale 1ns/100ps

module tb_gfx_top;
    import gfx_pkg::*;

    localparam int FB_WIDTH     = 32;
    localparam int FB_HEIGHT    = 24;
    localparam int H_TOTAL      = 40;
    localparam int V_TOTAL      = 28;
    localparam int H_SYNC_START = 34;
    localparam int H_SYNC_LEN   = 3;
    localparam int V_SYNC_START = 25;
    localparam int V_SYNC_LEN   = 2;
    localparam int N_DIRECTED   = 8;
    localparam int N_CMDS       = N_DIRECTED + 2;  // two random entries at the end
    localparam int CYCLE_LIMIT  = (N_CMDS + 2) * 3 * H_TOTAL * V_TOTAL + FB_WIDTH * FB_HEIGHT;

    logic     clk_100m;
    logic     rst;
    rect_t    cmd;
    logic     cmd_req;
    logic     cmd_ack;
    vga_out_t vga;

    rect_t       tbl [N_CMDS];       // stimulus
    int          tbl_npix [N_CMDS];  // expected pixel count or -1 for random entries
    cidx_t       model [FB_HEIGHT][FB_WIDTH];  // reference framebuffer
    logic [15:0] lfsr_state = 16'd45528;
    int          err_cnt = 0;
    int          n_checks = 0;
    int          cyc_cnt = 0;

    clk_gen u_clk (
        .clk_100m (clk_100m),
        .rst      (rst)
    );

    gfx_top #(
        .FB_WIDTH     (FB_WIDTH),
        .FB_HEIGHT    (FB_HEIGHT),
        .H_TOTAL      (H_TOTAL),
        .V_TOTAL      (V_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) u_gfx_top (
        .clk_100m (clk_100m),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_req  (cmd_req),
        .cmd_ack  (cmd_ack),
        .vga      (vga)
    );

    task automatic check_cidx(input string name, input cidx_t got, input cidx_t exp);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        n_checks++;
        if (got != exp) begin
            err_cnt++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // galois form with taps x^16+x^14+x^13+x^11+1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int nbits, output int val);
        int i;
        val = 0;
        for (i = 0; i < nbits; i++) begin
            val = val * 2 + int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic rand_coord(output int c);
        int v;
        take_bits(6, v);
        c = v % 48 - 8;  // -8..39 reaches past both edges
    endtask

    function automatic rect_t make_rect(input int x0, input int y0, input int x1,
                                        input int y1, input int c);
        rect_t r;
        r.x0   = coord_t'(x0);
        r.y0   = coord_t'(y0);
        r.x1   = coord_t'(x1);
        r.y1   = coord_t'(y1);
        r.cidx = cidx_t'(c);
        return r;
    endfunction

    task automatic fill_table();
        int i;
        int xa;
        int ya;
        int xb;
        int yb;
        int ci;
        tbl[0] = make_rect(4, 3, 12, 9, 5);  // wholly inside
        tbl_npix[0] = 63;
        tbl[1] = make_rect(20, 15, 14, 10, 9);  // both corners swapped
        tbl_npix[1] = 42;
        tbl[2] = make_rect(-5, -3, 6, 4, 3);  // clipped top left
        tbl_npix[2] = 35;
        tbl[3] = make_rect(25, 18, 40, 30, 12);  // clipped bottom right
        tbl_npix[3] = 42;
        tbl[4] = make_rect(-10, 20, 50, 22, 7);  // full width strip
        tbl_npix[4] = 96;
        tbl[5] = make_rect(33, 0, 45, 10, 15);  // off right edge
        tbl_npix[5] = 0;
        tbl[6] = make_rect(-20, -9, -1, -1, 14);  // off top left
        tbl_npix[6] = 0;
        tbl[7] = make_rect(10, 8, 16, 12, 10);  // overlaps 0 and 1
        tbl_npix[7] = 35;
        for (i = N_DIRECTED; i < N_CMDS; i++) begin
            rand_coord(xa);
            rand_coord(ya);
            rand_coord(xb);
            rand_coord(yb);
            take_bits(4, ci);
            tbl[i] = make_rect(xa, ya, xb, yb, ci);
            tbl_npix[i] = -1;  // count from the model
        end
    endtask

    // reference fill orders corners, clips and paints the inclusive box
    task automatic model_fill(input rect_t r, output int npix);
        int xa;
        int xb;
        int ya;
        int yb;
        int t;
        int x;
        int y;
        xa = int'($signed(r.x0));
        xb = int'($signed(r.x1));
        ya = int'($signed(r.y0));
        yb = int'($signed(r.y1));
        if (xa > xb) begin
            t = xa;
            xa = xb;
            xb = t;
        end
        if (ya > yb) begin
            t = ya;
            ya = yb;
            yb = t;
        end
        if (xa < 0) xa = 0;
        if (ya < 0) ya = 0;
        if (xb > FB_WIDTH - 1) xb = FB_WIDTH - 1;
        if (yb > FB_HEIGHT - 1) yb = FB_HEIGHT - 1;
        npix = 0;  // stays 0 when nothing is on screen
        for (y = ya; y <= yb; y++) begin
            for (x = xa; x <= xb; x++) begin
                model[y][x] = r.cidx;
                npix++;
            end
        end
    endtask

    // one cycle with no request pending where ack must stay low
    task automatic idle_cycle();
        @(negedge clk_100m);
        check_bit("cmd_ack", cmd_ack, 1'b0);
    endtask

    // four-phase handshake with inputs changed on the falling edge
    task automatic apply_cmd(input rect_t r, input int npix);
        int wait_n;
        @(negedge clk_100m);
        check_bit("cmd_ack", cmd_ack, 1'b0);
        cmd     = r;
        cmd_req = 1'b1;
        wait_n  = 0;
        do begin
            @(negedge clk_100m);
            wait_n++;
        end while (!cmd_ack);
        check_count("ack_latency", wait_n, npix + 2);  // accept, setup, one per pixel
        repeat (2) begin
            @(negedge clk_100m);
            check_bit("cmd_ack", cmd_ack, 1'b1);  // held while req stays high
        end
        cmd_req = 1'b0;
        @(negedge clk_100m);
        check_bit("cmd_ack", cmd_ack, 1'b0);  // drops one cycle after req
    endtask

    // checks sync shape, de runs and every pixel of the next full frame
    task automatic check_frame(input int tag);
        int   pix_n;
        int   run;
        int   lines;
        int   cyc;
        int   hs_rise;
        int   hs_len;
        int   hs_cnt;
        int   vs_len;
        int   x;
        int   y;
        logic prev_hs;
        while (vga.vsync) idle_cycle();  // skip a pulse already running
        while (!vga.vsync) idle_cycle();
        vs_len = 0;
        while (vga.vsync) begin
            vs_len++;
            idle_cycle();
        end
        check_count("vsync_len", vs_len, V_SYNC_LEN * H_TOTAL);
        pix_n   = 0;
        run     = 0;
        lines   = 0;
        cyc     = 0;
        hs_rise = -1;
        hs_len  = 0;
        hs_cnt  = 0;
        prev_hs = vga.hsync;
        while (pix_n < FB_WIDTH * FB_HEIGHT || vga.de) begin
            if (vga.de) begin
                x = pix_n % FB_WIDTH;
                y = pix_n / FB_WIDTH;
                if (y < FB_HEIGHT) begin
                    check_cidx($sformatf("vga.pix[%0d,%0d] after cmd %0d", x, y, tag),
                               vga.pix, model[y][x]);
                end
                run++;
                pix_n++;
            end else if (run != 0) begin
                check_count("de_run", run, FB_WIDTH);  // end of an active line
                lines++;
                run = 0;
            end
            if (vga.hsync && !prev_hs) begin
                if (hs_rise >= 0) begin
                    check_count("hsync_period", cyc - hs_rise, H_TOTAL);
                end
                hs_rise = cyc;
                hs_len  = 0;
            end
            if (vga.hsync) begin
                hs_len++;
            end
            if (!vga.hsync && prev_hs && hs_rise >= 0) begin
                check_count("hsync_len", hs_len, H_SYNC_LEN);
                hs_cnt++;
            end
            prev_hs = vga.hsync;
            cyc++;
            idle_cycle();
        end
        if (run != 0) begin
            check_count("de_run", run, FB_WIDTH);
            lines++;
        end
        check_count("de_lines", lines, FB_HEIGHT);
        // lines after vsync plus all active lines but the last
        check_count("hsync_pulses", hs_cnt,
                    (V_TOTAL - V_SYNC_START - V_SYNC_LEN) + (FB_HEIGHT - 1));
    endtask

    // watchdog
    always @(posedge clk_100m) begin
        cyc_cnt++;
        if (cyc_cnt >= CYCLE_LIMIT) begin
            $display("timeout: no progress within %0d cycles, run stopped", cyc_cnt);
            $display("summary: %0d checks, %0d errors, run incomplete", n_checks, err_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int idx;
        int npix;
        int x;
        int y;
        cmd     = '0;
        cmd_req = 1'b0;
        for (y = 0; y < FB_HEIGHT; y++) begin
            for (x = 0; x < FB_WIDTH; x++) begin
                model[y][x] = '0;  // clear pass result
            end
        end
        fill_table();
        repeat (3) begin  // in reset and just after release
            @(negedge clk_100m);
            check_bit("cmd_ack", cmd_ack, 1'b0);
            check_bit("vga.de", vga.de, 1'b0);
            check_bit("vga.hsync", vga.hsync, 1'b0);
            check_bit("vga.vsync", vga.vsync, 1'b0);
        end
        repeat (FB_WIDTH * FB_HEIGHT) idle_cycle();  // clear pass length
        check_frame(-1);
        for (idx = 0; idx < N_CMDS; idx++) begin
            model_fill(tbl[idx], npix);
            if (tbl_npix[idx] >= 0) begin
                check_count("model_npix", npix, tbl_npix[idx]);
            end
            apply_cmd(tbl[idx], npix);
            check_frame(idx);
        end
        $display("summary: %0d checks, %0d errors", n_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
hdl/gfx_pkg.sv
hdl/rect_fill_draw.sv
hdl/scan_timing.sv
hdl/frame_store.sv
hdl/gfx_top.sv
tb/clk_gen.sv
tb/tb_gfx_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the gfx_top testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f tb.f \
    --top-module tb_gfx_top \
    -Mdir obj_dir

./obj_dir/Vtb_gfx_top > sim.log 2>&1
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
